/* Bender.yml */
package:
  name: gmii_tx

sources:
  - design/gmii_pkg.sv
  - design/frame_pkg.sv
  - design/frame_ingress.sv
  - design/frame_fifo.sv
  - design/tx_framer.sv
  - design/gmii_serializer.sv
  - design/gmii_tx_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/tb_gmii_tx.sv

/* design/frame_fifo.sv */
`timescale 1ns/10ps

module frame_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                          gmii_txclk_offset,
    input  logic                          rst,
    input  logic                          wr_en,
    input  logic [frame_pkg::ENTRY_W-1:0] wr_entry,
    output logic                          full,
    input  logic                          rd_en,
    output logic [frame_pkg::ENTRY_W-1:0] rd_entry,
    output logic                          frame_avail
);
    import frame_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    // pointers carry one wrap bit above the address
    logic [AW:0]        wr_ptr;
    logic [AW:0]        rd_ptr;
    logic [AW:0]        frame_cnt;
    logic               empty;
    logic               frame_in;
    logic               frame_out;

    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign rd_entry = mem[rd_ptr[AW-1:0]];

    // a frame is complete once its last-marked entry is in
    assign frame_in = wr_en && wr_entry[ENTRY_W-1];
    assign frame_out = rd_en && rd_entry[ENTRY_W-1];
    assign frame_avail = (frame_cnt != '0);

    always_ff @(posedge gmii_txclk_offset)
    begin
        if (wr_en)
        begin
            mem[wr_ptr[AW-1:0]] <= wr_entry;
        end
    end

    always_ff @(posedge gmii_txclk_offset)
    begin
        if (rst)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_cnt <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({frame_in, frame_out})
                2'b10:   frame_cnt <= frame_cnt + 1'b1;
                2'b01:   frame_cnt <= frame_cnt - 1'b1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

    // the input side must honour full
    assert property (@(posedge gmii_txclk_offset) disable iff (rst) wr_en |-> !full)
    else
        $error("frame_fifo: write while full");

    // the framer must only pop buffered entries
    assert property (@(posedge gmii_txclk_offset) disable iff (rst) rd_en |-> !empty)
    else
        $error("frame_fifo: read while empty");

endmodule

/* design/frame_ingress.sv */
`timescale 1ns/10ps

module frame_ingress (
    input  logic                          gmii_txclk_offset,
    input  logic                          rst,
    input  logic                          host_req,
    input  logic [7:0]                    host_data,
    input  frame_pkg::byte_kind_e         host_kind,
    output logic                          host_ack,
    output logic                          wr_en,
    output logic [frame_pkg::ENTRY_W-1:0] wr_entry,
    input  logic                          full
);
    import frame_pkg::*;

    // WRITE is a write still pending on a full buffer
    typedef enum logic [1:0] {
        ING_WAIT    = 2'd0,
        ING_WRITE   = 2'd1,
        ING_ACK     = 2'd2,
        ING_RELEASE = 2'd3
    } ing_state_e;

    ing_state_e state;
    logic       req_q;

    // host holds data and kind stable while req is high
    assign wr_entry = {(host_kind == LAST_BYTE), host_data};
    assign wr_en = !full && (((state == ING_WAIT) && req_q) || (state == ING_WRITE));

    always_ff @(posedge gmii_txclk_offset)
    begin
        if (rst)
        begin
            req_q    <= 1'b0;
            state    <= ING_WAIT;
            host_ack <= 1'b0;
        end
        else
        begin
            req_q <= host_req;
            case (state)
                ING_WAIT:
                begin
                    if (req_q && full)
                    begin
                        state <= ING_WRITE;
                    end
                    else if (req_q)
                    begin
                        state    <= ING_ACK;
                        host_ack <= 1'b1;
                    end
                end
                ING_WRITE:
                begin
                    // back-pressure, ack waits for room
                    if (!full)
                    begin
                        state    <= ING_ACK;
                        host_ack <= 1'b1;
                    end
                end
                ING_ACK:
                begin
                    if (!req_q)
                    begin
                        state    <= ING_RELEASE;
                        host_ack <= 1'b0;
                    end
                end
                default:
                begin
                    state <= ING_WAIT;
                end
            endcase
        end
    end

    // ack only answers a request that was present on the previous edge
    assert property (@(posedge gmii_txclk_offset) disable iff (rst)
        $rose(host_ack) |-> $past(host_req))
    else
        $error("frame_ingress: ack rose without req");

endmodule

/* design/frame_pkg.sv */
package frame_pkg;

    // one buffer entry is the data byte with the last mark on top
    localparam int ENTRY_W = 9;

    // opcode sent by the host with every byte
    typedef enum logic {
        MID_BYTE  = 1'b0,
        LAST_BYTE = 1'b1
    } byte_kind_e;

endpackage

/* design/gmii_pkg.sv */
package gmii_pkg;

    // width of one byte on the GMII data pins
    localparam int BYTE_W = 8;

    // MII carries one nibble per clock on the low data bits
    localparam int NIBBLE_W = 4;

    // preamble and start-of-frame delimiter values
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE = 8'hD5;

    // number of preamble bytes ahead of the delimiter
    localparam int PREAMBLE_LEN = 7;

    // inter-frame gap in byte times, 96 bit times
    localparam int IFG_BYTES = 12;

    // framer states, in line order
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        GAP      = 3'd1,
        PREAMBLE = 3'd2,
        SFD      = 3'd3,
        DATA     = 3'd4
    } tx_state_e;

endpackage

/* design/gmii_serializer.sv */
`timescale 1ns/10ps

module gmii_serializer #(
    parameter bit GIGA_MODE = 1'b1
) (
    input  logic       gmii_txclk_offset,
    input  logic       rst,
    input  logic       sym_valid,
    input  logic [7:0] sym_data,
    input  logic       sym_ctrl,
    output logic       sym_take,
    output logic       gmii_txctrl,
    output logic [7:0] gmii_txdata
);
    import gmii_pkg::*;

    generate
        if (GIGA_MODE)
        begin : g_byte
            // one byte per clock, a symbol is taken every cycle
            assign sym_take = 1'b1;

            always_ff @(posedge gmii_txclk_offset)
            begin
                if (rst || !sym_valid)
                begin
                    gmii_txctrl <= 1'b0;
                    gmii_txdata <= 8'h00;
                end
                else
                begin
                    gmii_txctrl <= sym_ctrl;
                    gmii_txdata <= sym_data;
                end
            end
        end
        else
        begin : g_nibble
            logic                phase;
            logic                hold_ctrl;
            logic [NIBBLE_W-1:0] hold_nibble;

            // take on phase 0, the high nibble goes out on phase 1
            assign sym_take = !phase;

            always_ff @(posedge gmii_txclk_offset)
            begin
                if (!phase)
                begin
                    hold_nibble <= sym_valid ? sym_data[BYTE_W-1:NIBBLE_W] : '0;
                end
            end

            always_ff @(posedge gmii_txclk_offset)
            begin
                if (rst)
                begin
                    phase       <= 1'b0;
                    hold_ctrl   <= 1'b0;
                    gmii_txctrl <= 1'b0;
                    gmii_txdata <= 8'h00;
                end
                else
                begin
                    phase <= !phase;
                    if (phase)
                    begin
                        gmii_txctrl <= hold_ctrl;
                        gmii_txdata <= {{(BYTE_W - NIBBLE_W){1'b0}}, hold_nibble};
                    end
                    else if (sym_valid)
                    begin
                        hold_ctrl   <= sym_ctrl;
                        gmii_txctrl <= sym_ctrl;
                        gmii_txdata <= {{(BYTE_W - NIBBLE_W){1'b0}}, sym_data[NIBBLE_W-1:0]};
                    end
                    else
                    begin
                        hold_ctrl   <= 1'b0;
                        gmii_txctrl <= 1'b0;
                        gmii_txdata <= 8'h00;
                    end
                end
            end
        end
    endgenerate

endmodule

/* design/gmii_tx_top.sv */
`timescale 1ns/10ps

module gmii_tx_top #(
    parameter bit GIGA_MODE  = 1'b1,
    parameter int FIFO_DEPTH = 64
) (
    input  logic                  gmii_txclk_offset,
    input  logic                  rst,
    input  logic                  host_req,
    input  logic [7:0]            host_data,
    input  frame_pkg::byte_kind_e host_kind,
    output logic                  host_ack,
    output logic                  gmii_txctrl,
    output logic [7:0]            gmii_txdata
);
    import frame_pkg::*;

    // host side into the buffer
    logic               wr_en;
    logic [ENTRY_W-1:0] wr_entry;
    logic               full;

    // buffer into the framer
    logic               rd_en;
    logic [ENTRY_W-1:0] rd_entry;
    logic               frame_avail;

    // framer into the pin stage
    logic               sym_valid;
    logic [7:0]         sym_data;
    logic               sym_ctrl;
    logic               sym_take;

    frame_ingress u_ingress (
        .gmii_txclk_offset (gmii_txclk_offset),
        .rst               (rst),
        .host_req          (host_req),
        .host_data         (host_data),
        .host_kind         (host_kind),
        .host_ack          (host_ack),
        .wr_en             (wr_en),
        .wr_entry          (wr_entry),
        .full              (full)
    );

    frame_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .gmii_txclk_offset (gmii_txclk_offset),
        .rst               (rst),
        .wr_en             (wr_en),
        .wr_entry          (wr_entry),
        .full              (full),
        .rd_en             (rd_en),
        .rd_entry          (rd_entry),
        .frame_avail       (frame_avail)
    );

    tx_framer u_framer (
        .gmii_txclk_offset (gmii_txclk_offset),
        .rst               (rst),
        .frame_avail       (frame_avail),
        .rd_entry          (rd_entry),
        .rd_en             (rd_en),
        .sym_valid         (sym_valid),
        .sym_data          (sym_data),
        .sym_ctrl          (sym_ctrl),
        .sym_take          (sym_take)
    );

    gmii_serializer #(
        .GIGA_MODE (GIGA_MODE)
    ) u_ser (
        .gmii_txclk_offset (gmii_txclk_offset),
        .rst               (rst),
        .sym_valid         (sym_valid),
        .sym_data          (sym_data),
        .sym_ctrl          (sym_ctrl),
        .sym_take          (sym_take),
        .gmii_txctrl       (gmii_txctrl),
        .gmii_txdata       (gmii_txdata)
    );

endmodule

/* design/tx_framer.sv */
`timescale 1ns/10ps

module tx_framer (
    input  logic                          gmii_txclk_offset,
    input  logic                          rst,
    input  logic                          frame_avail,
    input  logic [frame_pkg::ENTRY_W-1:0] rd_entry,
    output logic                          rd_en,
    output logic                          sym_valid,
    output logic [7:0]                    sym_data,
    output logic                          sym_ctrl,
    input  logic                          sym_take
);
    import gmii_pkg::*;
    import frame_pkg::*;

    tx_state_e  state;
    // counts gap and preamble symbols
    logic [3:0] cnt;
    logic       xfer;
    logic       last_entry;

    assign xfer = sym_valid && sym_take;
    assign last_entry = rd_entry[ENTRY_W-1];

    // payload entries leave the buffer one per transfer
    assign rd_en = (state == DATA) && xfer;

    always_comb
    begin
        sym_valid = 1'b1;
        sym_ctrl  = 1'b1;
        sym_data  = 8'h00;
        case (state)
            GAP:
            begin
                sym_ctrl = 1'b0;
            end
            PREAMBLE:
            begin
                sym_data = PREAMBLE_BYTE;
            end
            SFD:
            begin
                sym_data = SFD_BYTE;
            end
            DATA:
            begin
                sym_data = rd_entry[7:0];
            end
            default:
            begin
                sym_valid = 1'b0;
                sym_ctrl  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge gmii_txclk_offset)
    begin
        if (rst)
        begin
            state <= IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    // only start once the whole frame is buffered
                    cnt <= '0;
                    if (frame_avail)
                    begin
                        state <= GAP;
                    end
                end
                GAP:
                begin
                    if (xfer && (cnt == 4'(IFG_BYTES - 1)))
                    begin
                        state <= PREAMBLE;
                        cnt   <= '0;
                    end
                    else if (xfer)
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PREAMBLE:
                begin
                    if (xfer && (cnt == 4'(PREAMBLE_LEN - 1)))
                    begin
                        state <= SFD;
                        cnt   <= '0;
                    end
                    else if (xfer)
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SFD:
                begin
                    if (xfer)
                    begin
                        state <= DATA;
                    end
                end
                DATA:
                begin
                    if (xfer && last_entry)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge gmii_txclk_offset) disable iff (rst)
        (state == GAP) |-> !sym_ctrl)
    else
        $error("tx_framer: ctrl high during gap");

    // a pop always belongs to a frame the buffer has counted as complete
    assert property (@(posedge gmii_txclk_offset) disable iff (rst) rd_en |-> frame_avail)
    else
        $error("tx_framer: payload pop with no complete frame buffered");

endmodule

/* tb.f */
design/gmii_pkg.sv
design/frame_pkg.sv
design/frame_ingress.sv
design/frame_fifo.sv
design/tx_framer.sv
design/gmii_serializer.sv
design/gmii_tx_top.sv
tb/tb_clkgen.sv
tb/tb_gmii_tx.sv

/* tb/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int CLK_PERIOD   = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic gmii_txclk_offset,
    output logic rst
);

    initial
    begin
        gmii_txclk_offset = 1'b0;
        forever #(CLK_PERIOD / 2) gmii_txclk_offset = ~gmii_txclk_offset;
    end

    // reset released on a rising edge, after the DUT has seen it
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge gmii_txclk_offset);
        rst <= 1'b0;
    end

endmodule

/* tb/tb_gmii_tx.sv */
`timescale 1ns/10ps

module tb_gmii_tx;
    import gmii_pkg::*;
    import frame_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_FRAMES  = 20;
    localparam int MAX_LEN     = 40;
    // frames from here on go back to back
    localparam int BURST_START = 14;
    localparam int ACK_LIMIT   = 2000;
    localparam int WATCHDOG_NS = NUM_FRAMES * 100 * 2 * CLK_PERIOD * 4;
    localparam logic [31:0] SEED = 32'h436e;

    logic             gmii_txclk_offset;
    logic             rst;

    // index 0 is the GMII instance, index 1 the MII instance
    logic [1:0]       host_req;
    logic [1:0][7:0]  host_data;
    byte_kind_e       host_kind [2];
    wire  [1:0]       host_ack;
    wire  [1:0]       gmii_txctrl;
    wire  [1:0][7:0]  gmii_txdata;

    logic [7:0]       frame_data [NUM_FRAMES][MAX_LEN];
    int               frame_len [NUM_FRAMES];
    int               model_q_giga [$];
    int               model_q_mii [$];
    int               rx_count [2];
    logic [1:0]       last_ack;
    logic [1:0]       last_req;
    int               hs_i;

    int               line_errors;
    int               gap_errors;
    int               hs_errors;

    tb_clkgen #(
        .CLK_PERIOD   (CLK_PERIOD),
        .RESET_CYCLES (2)
    ) u_clkgen (
        .gmii_txclk_offset (gmii_txclk_offset),
        .rst               (rst)
    );

    gmii_tx_top #(
        .GIGA_MODE  (1'b1),
        .FIFO_DEPTH (64)
    ) dut (
        .gmii_txclk_offset (gmii_txclk_offset),
        .rst               (rst),
        .host_req          (host_req[0]),
        .host_data         (host_data[0]),
        .host_kind         (host_kind[0]),
        .host_ack          (host_ack[0]),
        .gmii_txctrl       (gmii_txctrl[0]),
        .gmii_txdata       (gmii_txdata[0])
    );

    gmii_tx_top #(
        .GIGA_MODE  (1'b0),
        .FIFO_DEPTH (64)
    ) dut_mii (
        .gmii_txclk_offset (gmii_txclk_offset),
        .rst               (rst),
        .host_req          (host_req[1]),
        .host_data         (host_data[1]),
        .host_kind         (host_kind[1]),
        .host_ack          (host_ack[1]),
        .gmii_txctrl       (gmii_txctrl[1]),
        .gmii_txdata       (gmii_txdata[1])
    );

    // byte i of a frame as it must appear on the line
    function automatic logic [7:0] expected_line_byte(input int f, input int i);
        if (i < PREAMBLE_LEN)
            return 8'h55;
        else if (i == PREAMBLE_LEN)
            return 8'hD5;
        else
            return frame_data[f][i - PREAMBLE_LEN - 1];
    endfunction

    function automatic void record_sent_frame(input int idx, input int f);
        if (idx == 0)
            model_q_giga.push_back(f);
        else
            model_q_mii.push_back(f);
    endfunction

    function automatic int take_expected_frame(input int idx);
        int f;
        f = -1;
        if (idx == 0 && model_q_giga.size() > 0)
            f = model_q_giga.pop_front();
        else if (idx == 1 && model_q_mii.size() > 0)
            f = model_q_mii.pop_front();
        return f;
    endfunction

    // one four-phase transfer, entered and left on a falling edge
    task automatic send_byte(input int idx, input logic [7:0] data, input bit last);
        int waited;
        host_data[idx] = data;
        if (last)
            host_kind[idx] = LAST_BYTE;
        else
            host_kind[idx] = MID_BYTE;
        host_req[idx] = 1'b1;
        waited = 0;
        do
        begin
            @(negedge gmii_txclk_offset);
            waited++;
        end
        while (host_ack[idx] !== 1'b1 && waited < ACK_LIMIT);
        assert (host_ack[idx] === 1'b1)
        else
        begin
            hs_errors++;
            $display("host %0d: no ack within %0d cycles", idx, ACK_LIMIT);
        end
        host_req[idx] = 1'b0;
        waited = 0;
        do
        begin
            @(negedge gmii_txclk_offset);
            waited++;
        end
        while (host_ack[idx] !== 1'b0 && waited < ACK_LIMIT);
        assert (host_ack[idx] === 1'b0)
        else
        begin
            hs_errors++;
            $display("host %0d: ack did not fall after req fell", idx);
        end
    endtask

    task automatic drive_host(input int idx);
        int f;
        int b;
        for (f = 0; f < NUM_FRAMES; f++)
        begin
            record_sent_frame(idx, f);
            for (b = 0; b < frame_len[f]; b++)
            begin
                send_byte(idx, frame_data[f][b], b == frame_len[f] - 1);
                if (f < BURST_START)
                    repeat ($urandom_range(0, 3)) @(negedge gmii_txclk_offset);
            end
            if (f < BURST_START)
                repeat ($urandom_range(0, 20)) @(negedge gmii_txclk_offset);
        end
    endtask

    // rebuilds frames from the pins, pairing nibbles low first in MII mode
    task automatic watch_line(input int idx, input bit nibble_mode);
        logic [7:0] rx [$];
        logic [7:0] exp_b;
        logic [3:0] low_nib;
        bit         have_low;
        bit         in_frame;
        int         gap;
        int         min_gap;
        int         f;
        int         n;
        int         i;
        min_gap = nibble_mode ? 2 * IFG_BYTES : IFG_BYTES;
        gap = 0;
        in_frame = 0;
        have_low = 0;
        forever
        begin
            @(negedge gmii_txclk_offset);
            if (nibble_mode)
                assert (gmii_txdata[idx][7:4] == 4'h0)
                else
                begin
                    line_errors++;
                    $display("ERROR line %0d gmii_txdata[7:4]: got 0x%0h expected 0x0",
                        idx, gmii_txdata[idx][7:4]);
                end
            if (gmii_txctrl[idx])
            begin
                if (!in_frame)
                begin
                    assert (gap >= min_gap)
                    else
                    begin
                        gap_errors++;
                        $display("line %0d: only %0d idle cycles before a frame, need %0d",
                            idx, gap, min_gap);
                    end
                    in_frame = 1;
                    have_low = 0;
                    rx.delete();
                end
                if (!nibble_mode)
                    rx.push_back(gmii_txdata[idx]);
                else if (!have_low)
                begin
                    low_nib = gmii_txdata[idx][3:0];
                    have_low = 1;
                end
                else
                begin
                    rx.push_back({gmii_txdata[idx][3:0], low_nib});
                    have_low = 0;
                end
            end
            else
            begin
                assert (gmii_txdata[idx] == 8'h00)
                else
                begin
                    line_errors++;
                    $display("ERROR line %0d gmii_txdata while idle: got 0x%02h expected 0x00",
                        idx, gmii_txdata[idx]);
                end
                if (in_frame)
                begin
                    in_frame = 0;
                    gap = 0;
                    assert (!have_low)
                    else
                    begin
                        line_errors++;
                        $display("line %0d: frame ended on half a byte", idx);
                    end
                    f = take_expected_frame(idx);
                    assert (f >= 0)
                    else
                    begin
                        line_errors++;
                        $display("line %0d: frame on the line that was never sent", idx);
                    end
                    if (f >= 0)
                    begin
                        n = PREAMBLE_LEN + 1 + frame_len[f];
                        assert (rx.size() == n)
                        else
                        begin
                            line_errors++;
                            $display("ERROR line %0d frame length: got 0x%0h expected 0x%0h",
                                idx, rx.size(), n);
                        end
                        if (rx.size() < n)
                            n = rx.size();
                        for (i = 0; i < n; i++)
                        begin
                            exp_b = expected_line_byte(f, i);
                            assert (rx[i] == exp_b)
                            else
                            begin
                                line_errors++;
                                $display(
                                    "ERROR line %0d gmii_txdata byte %0d: got 0x%h expected 0x%h",
                                    idx, i, rx[i], exp_b);
                            end
                        end
                    end
                    rx_count[idx]++;
                end
                gap++;
            end
        end
    endtask

    // ack may only rise on a req and only fall after req has dropped
    always @(posedge gmii_txclk_offset)
    begin
        if (rst)
        begin
            last_ack = 2'b00;
            last_req = 2'b00;
        end
        else
        begin
            for (hs_i = 0; hs_i < 2; hs_i++)
            begin
                if (host_ack[hs_i] && !last_ack[hs_i])
                    assert (last_req[hs_i])
                    else
                    begin
                        hs_errors++;
                        $display("host %0d: ack rose while req was low", hs_i);
                    end
                if (!host_ack[hs_i] && last_ack[hs_i])
                    assert (!last_req[hs_i])
                    else
                    begin
                        hs_errors++;
                        $display("host %0d: ack fell while req was still high", hs_i);
                    end
                last_ack[hs_i] = host_ack[hs_i];
                last_req[hs_i] = host_req[hs_i];
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("errors: line %0d, gap %0d, handshake %0d", line_errors, gap_errors, hs_errors);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        int f;
        int b;
        host_req = 2'b00;
        host_data = '0;
        host_kind[0] = MID_BYTE;
        host_kind[1] = MID_BYTE;
        rx_count[0] = 0;
        rx_count[1] = 0;
        line_errors = 0;
        gap_errors = 0;
        hs_errors = 0;
        void'($urandom(SEED));
        for (f = 0; f < NUM_FRAMES; f++)
        begin
            frame_len[f] = $urandom_range(1, MAX_LEN);
            for (b = 0; b < MAX_LEN; b++)
                frame_data[f][b] = 8'($urandom_range(0, 255));
        end
        wait (rst == 1'b0);
        @(negedge gmii_txclk_offset);
        assert (host_ack == 2'b00)
        else
        begin
            hs_errors++;
            $display("ERROR host_ack after reset: got 0x%0h expected 0x0", host_ack);
        end
        // line pins come out of reset idle on both instances
        assert (gmii_txctrl == 2'b00)
        else
        begin
            line_errors++;
            $display("ERROR gmii_txctrl after reset: got 0x%0h expected 0x0", gmii_txctrl);
        end
        assert (gmii_txdata == '0)
        else
        begin
            line_errors++;
            $display("ERROR gmii_txdata after reset: got 0x%0h expected 0x0", gmii_txdata);
        end
        fork
            watch_line(0, 1'b0);
            watch_line(1, 1'b1);
        join_none
        fork
            drive_host(0);
            drive_host(1);
        join
        wait (rx_count[0] == NUM_FRAMES && rx_count[1] == NUM_FRAMES);
        repeat (40) @(negedge gmii_txclk_offset);
        assert (model_q_giga.size() == 0 && model_q_mii.size() == 0)
        else
        begin
            line_errors++;
            $display("sent frames left over that never reached the line");
        end
        $display("errors: line %0d, gap %0d, handshake %0d", line_errors, gap_errors, hs_errors);
        if (line_errors + gap_errors + hs_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
